/* common/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data and address width
`define CORE_XLEN 32

// Queue depth, also the number of credits fetch starts with.
// Must be a power of two between 2 and 16
`define CORE_QDEPTH 4

// First fetch address
`define CORE_PC_RESET 32'h0000_0000

`endif

/* common/core_pkg.sv */
`default_nettype none

`include "core_consts.svh"

package core_pkg;

  // One instruction queue entry
  typedef struct packed {
    logic [`CORE_XLEN-1:0] pc;
    logic [31:0]           inst;
  } fetch_pkt_t;

  // Pipeline restart request from execute
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] target;
  } redirect_t;

  // One retired instruction
  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    logic [4:0]            rd;
    logic                  we;
    logic [`CORE_XLEN-1:0] wdata;
  } retire_t;

  // Decoded operation, anything unsupported becomes OP_NOP
  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADDI,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_JAL
  } exec_op_e;

endpackage

`default_nettype wire

/* design/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_top (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  halt_i,

  output logic                       imem_req_o,
  output logic [`CORE_XLEN-1:0]      imem_addr_o,
  input  wire logic [31:0]           imem_rdata_i,

  output core_pkg::retire_t          retire_o
);

  import core_pkg::*;

  logic       push_valid;
  fetch_pkt_t push_pkt;
  logic       credit;
  logic       head_valid;
  fetch_pkt_t head_pkt;
  logic       pop;
  redirect_t  redirect;

  fetch_unit u_fetch (
    .clk          (clk),
    .rst          (rst),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .imem_rdata_i (imem_rdata_i),
    .credit_i     (credit),
    .redirect_i   (redirect),
    .push_valid_o (push_valid),
    .push_pkt_o   (push_pkt)
  );

  // Redirect doubles as the queue flush
  inst_queue u_queue (
    .clk          (clk),
    .rst          (rst),
    .push_valid_i (push_valid),
    .push_pkt_i   (push_pkt),
    .pop_i        (pop),
    .flush_i      (redirect.valid),
    .head_valid_o (head_valid),
    .head_pkt_o   (head_pkt),
    .credit_o     (credit)
  );

  exec_unit u_exec (
    .clk          (clk),
    .rst          (rst),
    .halt_i       (halt_i),
    .head_valid_i (head_valid),
    .head_pkt_i   (head_pkt),
    .pop_o        (pop),
    .redirect_o   (redirect),
    .retire_o     (retire_o)
  );

endmodule

`default_nettype wire

/* design/inst_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module inst_queue (
  input  wire logic                  clk,
  input  wire logic                  rst,

  input  wire logic                  push_valid_i,
  input  wire core_pkg::fetch_pkt_t  push_pkt_i,

  input  wire logic                  pop_i,
  input  wire logic                  flush_i,

  output logic                       head_valid_o,
  output core_pkg::fetch_pkt_t       head_pkt_o,
  output logic                       credit_o
);

  import core_pkg::*;

  localparam int PTR_W = $clog2(`CORE_QDEPTH);

  fetch_pkt_t entries [`CORE_QDEPTH];

  // Extra pointer bit tells full from empty
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;
  logic           do_pop;

  assign head_valid_o = (wr_ptr_q != rd_ptr_q);
  assign head_pkt_o   = entries[rd_ptr_q[PTR_W-1:0]];

  assign do_pop = pop_i && head_valid_o;

  // No credit on flush, fetch reloads its counter instead
  assign credit_o = do_pop && !flush_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Credits keep pushes within free slots
  always_ff @(posedge clk) begin
    if (push_valid_i) begin
      entries[wr_ptr_q[PTR_W-1:0]] <= push_pkt_i;
    end
  end

endmodule

`default_nettype wire

/* execute/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module exec_unit (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  halt_i,

  input  wire logic                  head_valid_i,
  input  wire core_pkg::fetch_pkt_t  head_pkt_i,
  output logic                       pop_o,

  output core_pkg::redirect_t        redirect_o,
  output core_pkg::retire_t          retire_o
);

  import core_pkg::*;

  // RV32I major opcodes
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [31:0]           inst;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [4:0]            rd;
  logic [4:0]            rs1;
  logic [4:0]            rs2;
  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] imm_j;
  logic [`CORE_XLEN-1:0] src1;
  logic [`CORE_XLEN-1:0] src2;
  logic [`CORE_XLEN-1:0] pc;
  logic [`CORE_XLEN-1:0] result;
  logic [`CORE_XLEN-1:0] target;
  exec_op_e              op;
  logic                  taken;
  logic                  writes_rd;
  logic                  rf_we;

  assign inst   = head_pkt_i.inst;
  assign pc     = head_pkt_i.pc;
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op = OP_NOP;
    case (opcode)
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          op = OP_ADDI;
        end
      end
      OPC_OP: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = OP_ADD;
          {7'b0100000, 3'b000}: op = OP_SUB;
          {7'b0000000, 3'b111}: op = OP_AND;
          {7'b0000000, 3'b110}: op = OP_OR;
          {7'b0000000, 3'b100}: op = OP_XOR;
          default:              op = OP_NOP;
        endcase
      end
      OPC_LUI: op = OP_LUI;
      OPC_BRANCH: begin
        if (funct3 == 3'b000) begin
          op = OP_BEQ;
        end else if (funct3 == 3'b001) begin
          op = OP_BNE;
        end
      end
      OPC_JAL: op = OP_JAL;
      default: op = OP_NOP;
    endcase
  end

  always_comb begin
    result    = '0;
    writes_rd = 1'b1;
    taken     = 1'b0;
    case (op)
      OP_ADDI: result = src1 + imm_i;
      OP_ADD:  result = src1 + src2;
      OP_SUB:  result = src1 - src2;
      OP_AND:  result = src1 & src2;
      OP_OR:   result = src1 | src2;
      OP_XOR:  result = src1 ^ src2;
      OP_LUI:  result = imm_u;
      OP_JAL: begin
        // Link address
        result = pc + `CORE_XLEN'(4);
        taken  = 1'b1;
      end
      OP_BEQ: begin
        writes_rd = 1'b0;
        taken     = (src1 == src2);
      end
      OP_BNE: begin
        writes_rd = 1'b0;
        taken     = (src1 != src2);
      end
      default: writes_rd = 1'b0;
    endcase
  end

  assign target = (op == OP_JAL) ? pc + imm_j : pc + imm_b;

  // Pop and retire happen together
  assign pop_o = head_valid_i && !halt_i;
  assign rf_we = pop_o && writes_rd && (rd != 5'd0);

  assign redirect_o.valid  = pop_o && taken;
  assign redirect_o.target = target;

  assign retire_o.valid = pop_o;
  assign retire_o.pc    = pc;
  assign retire_o.rd    = rd;
  assign retire_o.we    = rf_we;
  assign retire_o.wdata = result;

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we_i     (rf_we),
    .waddr_i  (rd),
    .wdata_i  (result),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (src1),
    .rdata2_o (src2)
  );

endmodule

`default_nettype wire

/* execute/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module reg_file (
  input  wire logic                  clk,
  input  wire logic                  rst,

  input  wire logic                  we_i,
  input  wire logic [4:0]            waddr_i,
  input  wire logic [`CORE_XLEN-1:0] wdata_i,

  input  wire logic [4:0]            raddr1_i,
  input  wire logic [4:0]            raddr2_i,
  output logic [`CORE_XLEN-1:0]      rdata1_o,
  output logic [`CORE_XLEN-1:0]      rdata2_o
);

  logic [`CORE_XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      // x0 never written, stays zero from reset
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

/* fetch/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module fetch_unit (
  input  wire logic                  clk,
  input  wire logic                  rst,

  // Instruction memory, fixed one cycle latency
  output logic                       imem_req_o,
  output logic [`CORE_XLEN-1:0]      imem_addr_o,
  input  wire logic [31:0]           imem_rdata_i,

  // Queue side
  input  wire logic                  credit_i,
  input  wire core_pkg::redirect_t   redirect_i,
  output logic                       push_valid_o,
  output core_pkg::fetch_pkt_t       push_pkt_o
);

  localparam int CREDIT_W = $clog2(`CORE_QDEPTH + 1);

  logic [`CORE_XLEN-1:0] pc_q;
  logic [CREDIT_W-1:0]   credits_q;
  logic                  run_q;
  logic                  issue;

  // Request issued last cycle, its word is on imem_rdata_i now
  logic                  inflight_q;
  logic [`CORE_XLEN-1:0] inflight_pc_q;

  // Every request already owns a queue slot
  assign issue = run_q && (credits_q != '0) && !redirect_i.valid;

  assign imem_req_o  = issue;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q      <= 1'b0;
      pc_q       <= `CORE_PC_RESET;
      credits_q  <= CREDIT_W'(`CORE_QDEPTH);
      inflight_q <= 1'b0;
    end else begin
      run_q      <= 1'b1;
      inflight_q <= issue;
      if (redirect_i.valid) begin
        // Queue is flushed in the same cycle, so all slots come back
        pc_q      <= redirect_i.target;
        credits_q <= CREDIT_W'(`CORE_QDEPTH);
      end else begin
        if (issue) begin
          pc_q <= pc_q + `CORE_XLEN'(4);
        end
        credits_q <= credits_q - CREDIT_W'(issue) + CREDIT_W'(credit_i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      inflight_pc_q <= pc_q;
    end
  end

  // A response arriving with a redirect is on the old path and is killed
  assign push_valid_o    = inflight_q && !redirect_i.valid;
  assign push_pkt_o.pc   = inflight_pc_q;
  assign push_pkt_o.inst = imem_rdata_i;

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/core_pkg.sv
fetch/fetch_unit.sv
design/inst_queue.sv
execute/reg_file.sv
execute/exec_unit.sv
design/core_top.sv
testbench/core_tb.sv

/* testbench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module core_tb;

  import core_pkg::*;

  localparam logic [31:0] NOP       = 32'h0000_0013;
  localparam int          MEM_WORDS = 256;

  logic                  clk;
  logic                  rst;
  logic                  halt_i;
  logic                  imem_req;
  logic [`CORE_XLEN-1:0] imem_addr;
  logic [31:0]           imem_rdata;
  retire_t               retire;

  logic [31:0] mem [MEM_WORDS];
  int          prog_len;
  logic [31:0] lfsr_state;

  // Reference machine state
  logic [31:0] ref_pc;
  logic [31:0] ref_regs [32];

  string       cur_test;
  int          test_errs;
  int          failed_tests;
  int          test_count;
  int          retire_count;
  logic [31:0] first_pc;
  logic [31:0] end_pc;
  logic        end_seen;
  logic        rst_sampled;

  core_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .halt_i       (halt_i),
    .imem_req_o   (imem_req),
    .imem_addr_o  (imem_addr),
    .imem_rdata_i (imem_rdata),
    .retire_o     (retire)
  );

  always #20 clk = ~clk;

  // High once the DUT has seen rst at a clock edge
  always @(posedge clk) begin
    rst_sampled <= rst;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Words past the program read as ADDI x0,x0,0
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr[31:2] < prog_len) begin
      return mem[addr[9:2]];
    end
    return NOP;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_br(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] word);
    mem[prog_len] = word;
    prog_len++;
  endtask

  // Executes the instruction at ref_pc and returns what should retire
  function automatic retire_t ref_step();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] next_pc;
    retire_t     r;
    inst    = mem_word(ref_pc);
    a       = ref_regs[inst[19:15]];
    b       = ref_regs[inst[24:20]];
    next_pc = ref_pc + 32'd4;
    r       = '0;
    r.valid = 1'b1;
    r.pc    = ref_pc;
    r.rd    = inst[11:7];
    case (inst[6:0])
      7'b0010011: begin
        r.we    = (inst[14:12] == 3'b000);
        r.wdata = a + {{20{inst[31]}}, inst[31:20]};
      end
      7'b0110011: begin
        r.we = 1'b1;
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: r.wdata = a + b;
          10'b0100000_000: r.wdata = a - b;
          10'b0000000_111: r.wdata = a & b;
          10'b0000000_110: r.wdata = a | b;
          10'b0000000_100: r.wdata = a ^ b;
          default:         r.we = 1'b0;
        endcase
      end
      7'b0110111: begin
        r.we    = 1'b1;
        r.wdata = {inst[31:12], 12'b0};
      end
      7'b1100011: begin
        if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b)) begin
          next_pc = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        r.we    = 1'b1;
        r.wdata = ref_pc + 32'd4;
        next_pc = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: r.we = 1'b0;
    endcase
    if (r.rd == 5'd0) begin
      r.we = 1'b0;
    end
    if (r.we) begin
      ref_regs[r.rd] = r.wdata;
    end
    ref_pc = next_pc;
    return r;
  endfunction

  // Memory answers one cycle after the request
  always @(posedge clk) begin
    if (imem_req) begin
      imem_rdata <= mem_word(imem_addr);
    end
  end

  always @(negedge clk) begin : check_retire
    retire_t exp;
    retire_t act;
    if (rst) begin
      // Old program still runs until the first edge with rst high
      if (rst_sampled) begin
        assert (!retire.valid && !imem_req) else begin
          $display("retire or request active during reset in %s", cur_test);
          test_errs++;
        end
      end
    end else if (retire.valid) begin
      exp = ref_step();
      act = retire;
      if (!exp.we) exp.wdata = '0;
      if (!act.we) act.wdata = '0;
      if (retire_count == 0) first_pc = act.pc;
      assert (act == exp) else begin
        $display("mismatch %s expected pc=%h rd=%0d we=%b wd=%h actual pc=%h rd=%0d we=%b wd=%h",
                 cur_test, exp.pc, exp.rd, exp.we, exp.wdata,
                 act.pc, act.rd, act.we, act.wdata);
        test_errs++;
      end
      if (act.pc == end_pc) end_seen = 1'b1;
      retire_count++;
    end
  end

  task automatic begin_test(input string name);
    @(posedge clk);
    rst       <= 1'b1;
    halt_i    <= 1'b0;
    cur_test  = name;
    test_errs = 0;
    @(negedge clk);
    retire_count = 0;
    end_seen     = 1'b0;
    prog_len     = 0;
    ref_pc       = `CORE_PC_RESET;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
  endtask

  // Program ends in a self-loop, which marks the end of the test
  task automatic release_reset();
    end_pc = `CORE_PC_RESET + 32'((prog_len - 1) * 4);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic wait_end(input int limit, input bit toggle_halt);
    int cycles;
    cycles = 0;
    while (!end_seen && cycles < limit) begin
      @(posedge clk);
      if (toggle_halt) halt_i <= (rand_bits(2) == 2'b11);
      cycles++;
    end
    assert (end_seen) else begin
      $display("timeout waiting for retirement in %s", cur_test);
      test_errs++;
    end
  endtask

  task automatic wait_retired(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (retire_count < n && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    assert (retire_count >= n) else begin
      $display("timeout waiting for retirement in %s", cur_test);
      test_errs++;
    end
  endtask

  task automatic end_test();
    $display("%s: %0d retired, %0d errors", cur_test, retire_count, test_errs);
    test_count++;
    if (test_errs != 0) failed_tests++;
  endtask

  initial begin : main
    int sel;
    int off;
    int hold_reqs;
    int ret_snap;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    clk          = 1'b0;
    rst          = 1'b1;
    halt_i       = 1'b0;
    imem_rdata   = NOP;
    lfsr_state   = 32'hedf62cf2;
    failed_tests = 0;
    test_count   = 0;
    prog_len     = 0;
    end_pc       = '1;

    begin_test("reset");
    emit(enc_addi(5'd1, 5'd0, 12'd7));
    emit(enc_jal(5'd0, 21'd0));
    release_reset();
    @(negedge clk);
    assert (!imem_req) else begin
      $display("request issued in the first cycle after reset");
      test_errs++;
    end
    @(negedge clk);
    assert (imem_req) else begin
      $display("no request one cycle after reset");
      test_errs++;
    end
    wait_end(200, 1'b0);
    assert (first_pc == `CORE_PC_RESET) else begin
      $display("mismatch %s expected %h actual %h", cur_test, `CORE_PC_RESET, first_pc);
      test_errs++;
    end
    end_test();

    begin_test("alu");
    emit(enc_addi(5'd1, 5'd0, 12'd100));
    emit(enc_addi(5'd2, 5'd0, 12'hfdb));  // -37
    emit(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(enc_r(7'h20, 3'b000, 5'd4, 5'd2, 5'd1));
    emit(enc_r(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
    emit(enc_r(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    emit(enc_r(7'h00, 3'b100, 5'd7, 5'd3, 5'd4));
    emit(enc_lui(5'd8, 20'habcde));
    emit(enc_addi(5'd8, 5'd8, 12'h123));
    emit(enc_r(7'h00, 3'b000, 5'd9, 5'd8, 5'd7));
    emit(enc_jal(5'd0, 21'd0));
    release_reset();
    wait_end(200, 1'b0);
    end_test();

    begin_test("x0_writes");
    emit(enc_addi(5'd0, 5'd0, 12'd55));
    emit(enc_lui(5'd0, 20'h12345));
    emit(enc_addi(5'd1, 5'd0, 12'd9));
    emit(enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    emit(enc_r(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
    emit(enc_r(7'h20, 3'b000, 5'd3, 5'd0, 5'd0));
    emit(enc_jal(5'd0, 21'd0));
    release_reset();
    wait_end(200, 1'b0);
    end_test();

    begin_test("control_flow");
    emit(enc_addi(5'd1, 5'd0, 12'd5));
    emit(enc_addi(5'd2, 5'd0, 12'd5));
    emit(enc_br(3'b000, 5'd1, 5'd2, 13'd12));  // taken to 20
    emit(enc_addi(5'd3, 5'd0, 12'd1));
    emit(enc_addi(5'd3, 5'd0, 12'd2));
    emit(enc_br(3'b001, 5'd1, 5'd2, 13'd8));   // not taken
    emit(enc_addi(5'd4, 5'd0, 12'd3));
    emit(enc_br(3'b000, 5'd1, 5'd4, 13'd8));   // not taken
    emit(enc_br(3'b001, 5'd1, 5'd4, 13'd8));   // taken to 40
    emit(enc_addi(5'd5, 5'd0, 12'd9));
    emit(enc_jal(5'd6, 21'd12));               // to 52, links 44
    emit(enc_addi(5'd7, 5'd0, 12'd1));
    emit(enc_addi(5'd7, 5'd0, 12'd2));
    emit(enc_r(7'h00, 3'b000, 5'd8, 5'd6, 5'd0));
    emit(enc_jal(5'd0, 21'd0));
    release_reset();
    wait_end(300, 1'b0);
    end_test();

    begin_test("halt");
    for (int i = 0; i < 16; i++) begin
      emit(enc_addi(5'(i % 4 + 1), 5'd1, 12'(i + 1)));
    end
    emit(enc_jal(5'd0, 21'd0));
    release_reset();
    wait_retired(3, 100);
    @(posedge clk);
    halt_i    <= 1'b1;
    ret_snap  = retire_count;
    hold_reqs = 0;
    repeat (20) begin
      @(negedge clk);
      if (imem_req) hold_reqs++;
    end
    assert (retire_count == ret_snap) else begin
      $display("mismatch %s expected 0 retirements actual %0d", cur_test,
               retire_count - ret_snap);
      test_errs++;
    end
    assert (hold_reqs <= `CORE_QDEPTH) else begin
      $display("%0d requests issued while halted, more than the queue holds", hold_reqs);
      test_errs++;
    end
    @(posedge clk);
    halt_i <= 1'b0;
    wait_end(300, 1'b0);
    end_test();

    begin_test("random");
    for (int i = 0; i < 200; i++) begin
      sel = rand_bits(4) % 10;
      rd  = 5'(rand_bits(3));
      rs1 = 5'(rand_bits(3));
      rs2 = 5'(rand_bits(3));
      off = 1 + rand_bits(3);
      // Forward only, never past the final self-loop
      if (i + off > 200) off = 200 - i;
      case (sel)
        0: emit(enc_addi(rd, rs1, 12'(rand_bits(12))));
        1: emit(enc_r(7'h00, 3'b000, rd, rs1, rs2));
        2: emit(enc_r(7'h20, 3'b000, rd, rs1, rs2));
        3: emit(enc_r(7'h00, 3'b111, rd, rs1, rs2));
        4: emit(enc_r(7'h00, 3'b110, rd, rs1, rs2));
        5: emit(enc_r(7'h00, 3'b100, rd, rs1, rs2));
        6: emit(enc_lui(rd, 20'(rand_bits(20))));
        7: emit(enc_br(3'b000, rs1, rs2, 13'(off * 4)));
        8: emit(enc_br(3'b001, rs1, rs2, 13'(off * 4)));
        default: emit(enc_jal(rd, 21'(off * 4)));
      endcase
    end
    emit(enc_jal(5'd0, 21'd0));
    release_reset();
    wait_end(5000, 1'b1);
    end_test();

    $display("%0d tests run, %0d failed", test_count, failed_tests);
    if (failed_tests == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
